//--- rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// log2 of the number of ROB entries
`define ROB_SIZE_EXP 4

// Micro-ops per incoming bundle
`define DEC_WIDTH 2

// Entries retired per cycle
`define COM_WIDTH 4

// Execution writeback ports
`define WB_WIDTH 2

// Physical tag width where a set MSB means no physical register
`define TAG_BITS 7

`endif

//--- robPkg.sv
`include "rob_settings.svh"

package robPkg;

    // Extra MSB tells wrapped sequence numbers apart
    typedef logic [`ROB_SIZE_EXP:0] SqN;
    typedef logic [`TAG_BITS-1:0] Tag;
    typedef logic [4:0] RegNm;

    // Completion classes in the order that range checks rely on
    typedef enum logic [3:0] {
        FlagsNone,
        FlagsBranch,
        FlagsFpNx,
        FlagsFpUf,
        FlagsFpOf,
        FlagsFpDz,
        FlagsFpNv,
        FlagsFence,
        FlagsIllegal,
        FlagsLdMisalign,
        FlagsTrap,
        FlagsNx
    } Flags;

    // FuRn ops are complete as soon as they are renamed
    typedef enum logic [1:0] {
        FuInt,
        FuFpu,
        FuRn,
        FuTrap
    } FuType;

    typedef struct packed {
        RegNm nmDst;
        Tag tagDst;
        FuType fu;
        logic valid;
    } InstBundleOp;

    typedef struct packed {
        InstBundleOp op;
        SqN sqN;
    } RenamedOp;

    typedef struct packed {
        SqN sqN;
        Flags flags;
        logic doNotCommit;
        logic valid;
    } WbResult;

    typedef struct packed {
        SqN sqN;
        logic taken;
    } BranchEvt;

    // Only the sqN MSB is kept since the rest is the entry index
    typedef struct packed {
        Flags flags;
        Tag tag;
        RegNm name;
        logic sqnMsb;
        logic isFp;
        logic valid;
    } RobEntry;

    typedef struct packed {
        RegNm nmDst;
        Tag tagDst;
        SqN sqN;
        logic isBranch;
        logic rollback;
        logic valid;
    } CommitOp;

    typedef struct packed {
        Flags flags;
        Tag tag;
        SqN sqN;
        RegNm name;
        logic valid;
    } TrapOp;

endpackage

//--- seqAllocator.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module seqAllocator (
    input  logic clk,
    input  logic rst,
    input  logic instReq,
    output logic instAck,
    input  robPkg::InstBundleOp bundle [`DEC_WIDTH],
    input  robPkg::BranchEvt branch,
    input  robPkg::SqN curSqN,
    output robPkg::RenamedOp renamed [`DEC_WIDTH],
    output logic enqValid
);
    localparam int decWidth = `DEC_WIDTH;
    localparam int robLength = 1 << `ROB_SIZE_EXP;

    typedef enum logic {
        HsIdle,
        HsAcked
    } HsState;

    HsState state;
    robPkg::SqN nextSqN;
    robPkg::SqN inFlight;
    logic hasRoom;

    // Entries between the head and the next free slot are occupied
    assign inFlight = nextSqN - curSqN;
    assign hasRoom = inFlight <= robPkg::SqN'(robLength - decWidth);

    always_ff @(posedge clk) begin
        robPkg::SqN sqn;
        sqn = nextSqN;
        enqValid <= 1'b0;
        if (rst) begin
            state <= HsIdle;
            instAck <= 1'b0;
            nextSqN <= '0;
        end else begin
            case (state)
                HsIdle: begin
                    // A mispredict in the same cycle would rewind under us
                    if (instReq && hasRoom && !branch.taken) begin
                        instAck <= 1'b1;
                        enqValid <= 1'b1;
                        state <= HsAcked;
                        for (int i = 0; i < decWidth; i++) begin
                            renamed[i].op <= bundle[i];
                            renamed[i].sqN <= sqn;
                            if (bundle[i].valid) begin
                                sqn = sqn + 1'b1;
                            end
                        end
                        nextSqN <= sqn;
                    end
                end
                HsAcked: begin
                    // Four-phase release
                    if (!instReq) begin
                        instAck <= 1'b0;
                        state <= HsIdle;
                    end
                end
                default: state <= HsIdle;
            endcase

            // Restart numbering right behind the mispredicted branch
            if (branch.taken) begin
                nextSqN <= branch.sqN + 1'b1;
            end
        end
    end

    ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(instAck) |-> $past(instReq));

endmodule

//--- renameSorter.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module renameSorter (
    input  robPkg::RenamedOp renamed [`DEC_WIDTH],
    input  logic enqValid,
    output robPkg::RenamedOp lanes [`DEC_WIDTH]
);
    localparam int decWidth = `DEC_WIDTH;
    localparam int laneBits = $clog2(decWidth);

    // Each ROB write port only ever sees sqNs with its own low bits
    always_comb begin
        for (int i = 0; i < decWidth; i++) begin
            lanes[i] = '0;
            for (int j = 0; j < decWidth; j++) begin
                if (enqValid && renamed[j].op.valid &&
                    renamed[j].sqN[laneBits-1:0] == laneBits'(i)) begin
                    lanes[i] = renamed[j];
                end
            end
        end
    end

endmodule

//--- commitSelect.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module commitSelect (
    input  robPkg::RobEntry headEntries [`COM_WIDTH],
    input  robPkg::SqN headSqN,
    input  logic stop,
    output robPkg::CommitOp commitOps [`COM_WIDTH],
    output robPkg::TrapOp trap,
    output logic [4:0] fpFlags,
    output logic [$clog2(`COM_WIDTH):0] retireCount,
    output logic [$clog2(`COM_WIDTH):0] commitCount,
    output logic setStop
);
    localparam int comWidth = `COM_WIDTH;
    localparam robPkg::Tag noRegTag = {1'b1, {(`TAG_BITS-1){1'b0}}};

    always_comb begin
        logic done;
        robPkg::RobEntry e;
        robPkg::SqN sqn;

        // Paused for one cycle after a trap
        done = stop;
        trap = '0;
        fpFlags = '0;
        retireCount = '0;
        commitCount = '0;
        setStop = 1'b0;

        for (int i = 0; i < comWidth; i++) begin
            e = headEntries[i];
            sqn = headSqN + robPkg::SqN'(i);
            commitOps[i] = '0;

            if (done || !e.valid || e.flags == robPkg::FlagsNx) begin
                // Strict program order so nothing passes an unfinished entry
                done = 1'b1;
            end else begin
                commitOps[i].valid = 1'b1;
                commitOps[i].nmDst = e.name;
                commitOps[i].tagDst = e.tag;
                commitOps[i].sqN = sqn;
                commitOps[i].isBranch = e.flags == robPkg::FlagsBranch;
                commitCount = commitCount + 1'b1;

                // Synchronous exceptions do not count as retired
                if (e.flags <= robPkg::FlagsFence) begin
                    retireCount = retireCount + 1'b1;
                end

                if (e.flags >= robPkg::FlagsFence) begin
                    trap.valid = 1'b1;
                    trap.flags = e.flags;
                    trap.tag = e.tag;
                    trap.sqN = sqn;
                    trap.name = e.name;
                    setStop = 1'b1;
                    done = 1'b1;

                    // Faulting op never wrote its result
                    if (e.flags >= robPkg::FlagsIllegal &&
                        e.flags <= robPkg::FlagsLdMisalign) begin
                        commitOps[i].nmDst = '0;
                        commitOps[i].tagDst = noRegTag;
                    end
                end else if (e.isFp && e.flags >= robPkg::FlagsFpNx &&
                             e.flags <= robPkg::FlagsFpNv) begin
                    // Bit order NX UF OF DZ NV follows the enum order
                    fpFlags[3'(e.flags - robPkg::FlagsFpNx)] = 1'b1;
                    if (e.flags == robPkg::FlagsFpUf || e.flags == robPkg::FlagsFpOf) begin
                        fpFlags[0] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- reorderBuffer.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module reorderBuffer #(
    parameter int sizeExp = `ROB_SIZE_EXP
) (
    input  logic clk,
    input  logic rst,
    input  robPkg::RenamedOp lanes [`DEC_WIDTH],
    input  robPkg::WbResult wbResults [`WB_WIDTH],
    input  robPkg::BranchEvt branch,
    output robPkg::SqN curSqN,
    output robPkg::CommitOp commitOps [`COM_WIDTH],
    output robPkg::TrapOp trap,
    output logic [4:0] fpFlags,
    output logic [$clog2(`COM_WIDTH):0] retireCount,
    output logic mispredFlush
);
    localparam int length = 1 << sizeExp;
    localparam int decWidth = `DEC_WIDTH;
    localparam int comWidth = `COM_WIDTH;
    localparam int wbWidth = `WB_WIDTH;
    localparam int laneBits = $clog2(decWidth);

    typedef enum logic [1:0] {
        Normal,
        Replay,
        ReplayEnd
    } ReplayState;

    robPkg::RobEntry entries [length];
    robPkg::SqN baseIndex;
    logic stop;
    ReplayState state;
    robPkg::SqN replayIter;
    robPkg::SqN replayEndSqN;

    robPkg::SqN readBase;
    robPkg::RobEntry headEntries [comWidth];
    logic inReplay [comWidth];
    logic replayDone;

    robPkg::CommitOp selOps [comWidth];
    robPkg::TrapOp selTrap;
    logic [4:0] selFpFlags;
    logic [$clog2(comWidth):0] selRetire;
    logic [$clog2(comWidth):0] selCount;
    logic selStop;

    // Age by signed distance so it stays valid across the wrap
    function automatic logic isYounger(robPkg::SqN a, robPkg::SqN b);
        robPkg::SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    assign curSqN = baseIndex;

    // Commit and replay share the same four read ports
    assign readBase = (state == Replay) ? replayIter : baseIndex;

    always_comb begin
        logic [sizeExp-1:0] idx;
        for (int i = 0; i < comWidth; i++) begin
            idx = readBase[sizeExp-1:0] + sizeExp'(i);
            headEntries[i] = entries[idx];
            inReplay[i] = !isYounger(replayIter + robPkg::SqN'(i), replayEndSqN);
        end
    end

    // Branch falls inside the current group of four
    assign replayDone = !isYounger(replayEndSqN, replayIter + robPkg::SqN'(comWidth - 1));

    commitSelect i_commitSelect (
        .headEntries(headEntries),
        .headSqN(baseIndex),
        .stop(stop),
        .commitOps(selOps),
        .trap(selTrap),
        .fpFlags(selFpFlags),
        .retireCount(selRetire),
        .commitCount(selCount),
        .setStop(selStop)
    );

    always_ff @(posedge clk) begin
        logic [sizeExp-1:0] idx;

        // Outputs are single-cycle pulses
        for (int i = 0; i < comWidth; i++) begin
            commitOps[i] <= '0;
        end
        trap <= '0;
        fpFlags <= '0;
        retireCount <= '0;

        if (rst) begin
            baseIndex <= '0;
            stop <= 1'b0;
            state <= Normal;
            mispredFlush <= 1'b0;
            for (int i = 0; i < length; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            stop <= 1'b0;

            if (branch.taken) begin
                // Kill the wrong path, then walk head..branch again
                for (int i = 0; i < length; i++) begin
                    if (isYounger(robPkg::SqN'({entries[i].sqnMsb, sizeExp'(i)}),
                                  branch.sqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
                state <= Replay;
                replayIter <= baseIndex;
                replayEndSqN <= branch.sqN;
            end else if (state == Replay) begin
                mispredFlush <= 1'b1;
                for (int i = 0; i < comWidth; i++) begin
                    if (inReplay[i]) begin
                        commitOps[i].valid <= 1'b1;
                        commitOps[i].rollback <= 1'b1;
                        commitOps[i].sqN <= replayIter + robPkg::SqN'(i);
                        commitOps[i].nmDst <= (headEntries[i].flags == robPkg::FlagsTrap) ?
                            '0 : headEntries[i].name;
                        commitOps[i].tagDst <= headEntries[i].tag;
                        commitOps[i].isBranch <= headEntries[i].flags == robPkg::FlagsBranch;
                    end
                end
                replayIter <= replayIter + robPkg::SqN'(comWidth);
                if (replayDone) begin
                    state <= ReplayEnd;
                end
            end else if (state == ReplayEnd) begin
                mispredFlush <= 1'b0;
                state <= Normal;
            end else begin
                for (int i = 0; i < comWidth; i++) begin
                    commitOps[i] <= selOps[i];
                    idx = baseIndex[sizeExp-1:0] + sizeExp'(i);
                    if (selOps[i].valid) begin
                        entries[idx].valid <= 1'b0;
                    end
                end
                trap <= selTrap;
                fpFlags <= selFpFlags;
                retireCount <= selRetire;
                stop <= selStop;
                baseIndex <= baseIndex + robPkg::SqN'(selCount);
            end

            // Results from the wrong path are dropped
            for (int i = 0; i < wbWidth; i++) begin
                if (wbResults[i].valid && !wbResults[i].doNotCommit &&
                    !(branch.taken && isYounger(wbResults[i].sqN, branch.sqN))) begin
                    entries[wbResults[i].sqN[sizeExp-1:0]].flags <= wbResults[i].flags;
                end
            end

            if (!branch.taken) begin
                for (int i = 0; i < decWidth; i++) begin
                    if (lanes[i].op.valid) begin
                        idx = {lanes[i].sqN[sizeExp-1:laneBits], laneBits'(i)};
                        entries[idx].valid <= 1'b1;
                        entries[idx].tag <= lanes[i].op.tagDst;
                        entries[idx].name <= lanes[i].op.nmDst;
                        entries[idx].sqnMsb <= lanes[i].sqN[sizeExp];
                        entries[idx].isFp <= lanes[i].op.fu == robPkg::FuFpu;
                        case (lanes[i].op.fu)
                            robPkg::FuRn: entries[idx].flags <= robPkg::FlagsNone;
                            robPkg::FuTrap: entries[idx].flags <= robPkg::FlagsTrap;
                            default: entries[idx].flags <= robPkg::FlagsNx;
                        endcase
                    end
                end
            end
        end
    end

    for (genvar g = 0; g < wbWidth; g++) begin : gWbCheck
        wbNotPending: assert property (@(posedge clk) disable iff (rst)
            wbResults[g].valid |-> wbResults[g].flags != robPkg::FlagsNx);
    end

    // Survivors of a mispredict must still be in the buffer
    for (genvar g = 0; g < comWidth; g++) begin : gReplayCheck
        replayHitsValid: assert property (@(posedge clk) disable iff (rst)
            (state == Replay && !branch.taken && inReplay[g]) |-> headEntries[g].valid);
    end

endmodule

//--- robTop.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module robTop (
    input  logic clk,
    input  logic rst,
    input  logic instReq,
    output logic instAck,
    input  robPkg::InstBundleOp bundle [`DEC_WIDTH],
    input  robPkg::WbResult wbResults [`WB_WIDTH],
    input  robPkg::BranchEvt branch,
    output robPkg::SqN curSqN,
    output robPkg::CommitOp commitOps [`COM_WIDTH],
    output robPkg::TrapOp trap,
    output logic [4:0] fpFlags,
    output logic [$clog2(`COM_WIDTH):0] retireCount,
    output logic mispredFlush
);
    robPkg::RenamedOp renamed [`DEC_WIDTH];
    robPkg::RenamedOp lanes [`DEC_WIDTH];
    logic enqValid;

    seqAllocator i_seqAllocator (
        .clk(clk),
        .rst(rst),
        .instReq(instReq),
        .instAck(instAck),
        .bundle(bundle),
        .branch(branch),
        .curSqN(curSqN),
        .renamed(renamed),
        .enqValid(enqValid)
    );

    renameSorter i_renameSorter (
        .renamed(renamed),
        .enqValid(enqValid),
        .lanes(lanes)
    );

    reorderBuffer #(
        .sizeExp(`ROB_SIZE_EXP)
    ) i_reorderBuffer (
        .clk(clk),
        .rst(rst),
        .lanes(lanes),
        .wbResults(wbResults),
        .branch(branch),
        .curSqN(curSqN),
        .commitOps(commitOps),
        .trap(trap),
        .fpFlags(fpFlags),
        .retireCount(retireCount),
        .mispredFlush(mispredFlush)
    );

endmodule

//--- tbRobTop.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module tbRobTop;
    localparam int maxOps = 4;
    localparam int timeoutCycles = 200;
    localparam int numRows = 6;

    typedef struct {
        string label;
        int nameBase;
        logic [3:0] fpMask;
        robPkg::Flags wb [maxOps];
        logic shuffle;
        int brIdx;
        int expNames [maxOps];
        int expCount;
        logic [4:0] expFp;
        int trapIdx;
        robPkg::Flags trapClass;
    } ScenarioRow;

    logic clk;
    logic rst;
    logic instReq;
    logic instAck;
    robPkg::InstBundleOp bundle [`DEC_WIDTH];
    robPkg::WbResult wbResults [`WB_WIDTH];
    robPkg::BranchEvt branch;
    robPkg::SqN curSqN;
    robPkg::CommitOp commitOps [`COM_WIDTH];
    robPkg::TrapOp trap;
    logic [4:0] fpFlags;
    logic [$clog2(`COM_WIDTH):0] retireCount;
    logic mispredFlush;

    ScenarioRow rows [numRows];
    int errors;
    int rowsPassed;
    int rowsFailed;
    int unsigned lcgState;
    robPkg::SqN tbNext;

    // Observed traffic of the current scenario
    int cmNames [$];
    int cmSqns [$];
    int rbNames [$];
    logic [4:0] fpAcc;
    int retAcc;
    logic trapSeen;
    robPkg::SqN trapSqn;
    robPkg::Flags trapFlags;

    robTop i_dut (
        .clk(clk),
        .rst(rst),
        .instReq(instReq),
        .instAck(instAck),
        .bundle(bundle),
        .wbResults(wbResults),
        .branch(branch),
        .curSqN(curSqN),
        .commitOps(commitOps),
        .trap(trap),
        .fpFlags(fpFlags),
        .retireCount(retireCount),
        .mispredFlush(mispredFlush)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `COM_WIDTH; i++) begin
                if (commitOps[i].valid && commitOps[i].rollback) begin
                    rbNames.push_back(int'(commitOps[i].nmDst));
                end else if (commitOps[i].valid) begin
                    cmNames.push_back(int'(commitOps[i].nmDst));
                    cmSqns.push_back(int'(commitOps[i].sqN));
                end
            end
            fpAcc = fpAcc | fpFlags;
            retAcc = retAcc + int'(retireCount);
            if (trap.valid) begin
                trapSeen = 1'b1;
                trapSqn = trap.sqN;
                trapFlags = trap.flags;
                for (int i = 0; i < `COM_WIDTH; i++) begin
                    if (commitOps[i].valid && !commitOps[i].rollback &&
                        $signed(robPkg::SqN'(commitOps[i].sqN - trap.sqN)) > 0) begin
                        $display("at %0t ns an op younger than the trap committed with it",
                            $time);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic checkVal(input string sigName, input int expVal, input int gotVal);
        if (expVal != gotVal) begin
            $display("mismatch at %0t ns: %s expected %0d got %0d",
                $time, sigName, expVal, gotVal);
            errors++;
        end
    endtask

    task automatic waitAck(input logic level);
        logic seen;
        seen = 1'b0;
        for (int c = 0; c < timeoutCycles && !seen; c++) begin
            @(negedge clk);
            seen = (instAck == level);
        end
        if (!seen) begin
            $display("timeout while waiting for instAck to become %0d", level);
            errors++;
        end
    endtask

    task automatic waitFlush(input logic level);
        logic seen;
        seen = 1'b0;
        for (int c = 0; c < timeoutCycles && !seen; c++) begin
            @(negedge clk);
            seen = (mispredFlush == level);
        end
        if (!seen) begin
            $display("timeout while waiting for mispredFlush to become %0d", level);
            errors++;
        end
    endtask

    task automatic waitHead(input robPkg::SqN expHead);
        logic seen;
        seen = 1'b0;
        for (int c = 0; c < timeoutCycles && !seen; c++) begin
            @(negedge clk);
            seen = (curSqN == expHead);
        end
        if (!seen) begin
            checkVal("curSqN", int'(expHead), int'(curSqN));
        end
    endtask

    // Four-phase handshake for one bundle of two ops
    task automatic sendBundle(input int firstName, input logic [1:0] fpMask);
        @(posedge clk);
        for (int i = 0; i < `DEC_WIDTH; i++) begin
            bundle[i] <= '{nmDst: robPkg::RegNm'(firstName + i),
                           tagDst: robPkg::Tag'(firstName + i),
                           fu: fpMask[i] ? robPkg::FuFpu : robPkg::FuInt,
                           valid: 1'b1};
        end
        instReq <= 1'b1;
        waitAck(1'b1);
        @(posedge clk);
        instReq <= 1'b0;
        waitAck(1'b0);
        tbNext = tbNext + robPkg::SqN'(`DEC_WIDTH);
    endtask

    task automatic writeBack(input robPkg::SqN sqn, input robPkg::Flags flags);
        @(posedge clk);
        wbResults[0] <= '{sqN: sqn, flags: flags, doNotCommit: 1'b0, valid: 1'b1};
        @(posedge clk);
        wbResults[0] <= '0;
    endtask

    task automatic runRow(input int r);
        ScenarioRow row;
        int order [maxOps];
        int j;
        int tmp;
        int n;
        int errStart;
        int expRetire;
        robPkg::SqN rowBase;
        row = rows[r];
        errStart = errors;
        rowBase = tbNext;
        cmNames.delete();
        cmSqns.delete();
        rbNames.delete();
        fpAcc = '0;
        retAcc = 0;
        trapSeen = 1'b0;

        for (int b = 0; b < maxOps; b += 2) begin
            sendBundle(row.nameBase + b, row.fpMask[b+:2]);
        end
        n = maxOps;

        if (row.brIdx >= 0) begin
            @(posedge clk);
            branch <= '{sqN: rowBase + robPkg::SqN'(row.brIdx), taken: 1'b1};
            @(posedge clk);
            branch <= '0;
            waitFlush(1'b1);
            waitFlush(1'b0);
            @(posedge clk);
            // Replay covers the head through the branch
            checkVal("rollback count", row.brIdx + 1, rbNames.size());
            for (int k = 0; k <= row.brIdx && k < rbNames.size(); k++) begin
                checkVal("rollback nmDst", row.nameBase + k, rbNames[k]);
            end
            n = row.brIdx + 1;
            tbNext = rowBase + robPkg::SqN'(n);
        end

        // Squashed ops get results too and must still never commit
        for (int k = 0; k < maxOps; k++) begin
            order[k] = row.shuffle ? k : maxOps - 1 - k;
        end
        if (row.shuffle) begin
            for (int k = maxOps - 1; k > 0; k--) begin
                j = int'(lcgNext() % (k + 1));
                tmp = order[k];
                order[k] = order[j];
                order[j] = tmp;
            end
        end
        for (int k = 0; k < maxOps; k++) begin
            writeBack(rowBase + robPkg::SqN'(order[k]), row.wb[order[k]]);
        end

        waitHead(tbNext);
        @(posedge clk);
        checkVal("commit count", row.expCount, cmNames.size());
        for (int k = 0; k < row.expCount && k < cmNames.size(); k++) begin
            checkVal("commitOps.nmDst", row.expNames[k], cmNames[k]);
            checkVal("commitOps.sqN", int'(robPkg::SqN'(rowBase + robPkg::SqN'(k))),
                cmSqns[k]);
        end
        checkVal("fpFlags", int'(row.expFp), int'(fpAcc));
        // Synchronous exceptions commit without retiring
        expRetire = row.expCount;
        if (row.trapIdx >= 0 && row.trapClass != robPkg::FlagsFence) begin
            expRetire = expRetire - 1;
        end
        checkVal("retireCount", expRetire, retAcc);
        if (row.trapIdx >= 0 && !trapSeen) begin
            $display("no trap record appeared for the excepting op");
            errors++;
        end else if (row.trapIdx >= 0) begin
            checkVal("trap.sqN", int'(robPkg::SqN'(rowBase + robPkg::SqN'(row.trapIdx))),
                int'(trapSqn));
            checkVal("trap.flags", int'(row.trapClass), int'(trapFlags));
        end else if (trapSeen) begin
            $display("a trap record appeared although no op excepted");
            errors++;
        end
        reportTest(row.label, errStart);
    endtask

    task automatic reportTest(input string label, input int errStart);
        if (errors == errStart) begin
            rowsPassed++;
            $display("test %s: ok", label);
        end else begin
            rowsFailed++;
            $display("test %s: failed", label);
        end
    endtask

    task automatic fullBufferTest();
        int errStart;
        logic acked;
        robPkg::SqN head;
        errStart = errors;
        head = tbNext;
        for (int b = 0; b < 8; b++) begin
            sendBundle(b * 2 + 1, 2'b00);
        end
        @(posedge clk);
        instReq <= 1'b1;
        acked = 1'b0;
        repeat (50) begin
            @(negedge clk);
            acked = acked | instAck;
        end
        if (acked) begin
            $display("instAck rose while the buffer was full");
            errors++;
        end
        // Retiring the two oldest ops frees room for one bundle
        @(posedge clk);
        wbResults[0] <= '{sqN: head, flags: robPkg::FlagsNone, doNotCommit: 1'b0, valid: 1'b1};
        wbResults[1] <= '{sqN: head + 1'b1, flags: robPkg::FlagsNone,
                          doNotCommit: 1'b0, valid: 1'b1};
        @(posedge clk);
        wbResults[0] <= '0;
        wbResults[1] <= '0;
        waitAck(1'b1);
        @(posedge clk);
        instReq <= 1'b0;
        waitAck(1'b0);
        reportTest("full buffer", errStart);
    endtask

    initial begin
        int errStart;
        rst = 1'b1;
        instReq = 1'b0;
        branch = '0;
        for (int i = 0; i < `DEC_WIDTH; i++) begin
            bundle[i] = '0;
        end
        for (int i = 0; i < `WB_WIDTH; i++) begin
            wbResults[i] = '0;
        end
        errors = 0;
        rowsPassed = 0;
        rowsFailed = 0;
        lcgState = 44;
        tbNext = '0;
        fpAcc = '0;
        retAcc = 0;
        trapSeen = 1'b0;

        rows[0] = '{"in-order", 1, 4'b0000,
            '{robPkg::FlagsNone, robPkg::FlagsNone, robPkg::FlagsNone, robPkg::FlagsNone},
            1'b1, -1, '{1, 2, 3, 4}, 4, 5'b00000, -1, robPkg::FlagsNone};
        rows[1] = '{"fp underflow", 5, 4'b0001,
            '{robPkg::FlagsFpUf, robPkg::FlagsNone, robPkg::FlagsNone, robPkg::FlagsNone},
            1'b0, -1, '{5, 6, 7, 8}, 4, 5'b00011, -1, robPkg::FlagsNone};
        rows[2] = '{"fp divide by zero", 9, 4'b0100,
            '{robPkg::FlagsNone, robPkg::FlagsNone, robPkg::FlagsFpDz, robPkg::FlagsNone},
            1'b1, -1, '{9, 10, 11, 12}, 4, 5'b01000, -1, robPkg::FlagsNone};
        rows[3] = '{"illegal instruction", 13, 4'b0000,
            '{robPkg::FlagsNone, robPkg::FlagsIllegal, robPkg::FlagsNone, robPkg::FlagsNone},
            1'b0, -1, '{13, 0, 15, 16}, 4, 5'b00000, 1, robPkg::FlagsIllegal};
        rows[4] = '{"mispredict", 17, 4'b0000,
            '{robPkg::FlagsNone, robPkg::FlagsBranch, robPkg::FlagsNone, robPkg::FlagsNone},
            1'b1, 1, '{17, 18, 0, 0}, 2, 5'b00000, -1, robPkg::FlagsNone};
        rows[5] = '{"after mispredict", 21, 4'b0000,
            '{robPkg::FlagsNone, robPkg::FlagsNone, robPkg::FlagsNone, robPkg::FlagsNone},
            1'b1, -1, '{21, 22, 23, 24}, 4, 5'b00000, -1, robPkg::FlagsNone};

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        errStart = errors;
        checkVal("instAck", 0, int'(instAck));
        for (int i = 0; i < `COM_WIDTH; i++) begin
            checkVal("commitOps.valid", 0, int'(commitOps[i].valid));
        end
        checkVal("trap.valid", 0, int'(trap.valid));
        checkVal("mispredFlush", 0, int'(mispredFlush));
        checkVal("curSqN", 0, int'(curSqN));
        checkVal("fpFlags", 0, int'(fpFlags));
        checkVal("retireCount", 0, int'(retireCount));
        reportTest("reset", errStart);

        for (int r = 0; r < numRows; r++) begin
            runRow(r);
        end
        fullBufferTest();

        $display("tests passed %0d, failed %0d, errors %0d", rowsPassed, rowsFailed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
robPkg.sv
seqAllocator.sv
renameSorter.sv
commitSelect.sv
reorderBuffer.sv
robTop.sv
tbRobTop.sv

//--- run.sh
#!/bin/sh
# Build and run the ROB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tbRobTop -o tbRobTop
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tbRobTop > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
